// File: logic/rsv_cfg_pkg.sv
package rsv_cfg_pkg;

	// physical register number
	typedef logic [4:0] prf_code_t;

	// register value
	typedef logic [31:0] prf_data_t;

	// reorder buffer id
	typedef logic [5:0] rob_id_t;

endpackage

// File: logic/rsv_unit_pkg.sv
package rsv_unit_pkg;

	// execution class of an instruction
	typedef enum logic {
		UNIT_ALU    = 1'b0,
		UNIT_MULDIV = 1'b1
	} exec_unit_e;

	// class that won the read ports last
	typedef enum logic {
		LAST_ALU    = 1'b0,
		LAST_MULDIV = 1'b1
	} arb_last_e;

endpackage

// File: logic/rsv_entry_table.sv
`timescale 1ns/1ns

module rsv_entry_table
	import rsv_cfg_pkg::*;
	import rsv_unit_pkg::*;
#(
	parameter int ENTRY_NUMS = 8
) (
	input	logic						clk,
	input	logic						i_rst,
	input	logic						i_flush,

	input	logic						i_dsp_vld,
	input	exec_unit_e					i_dsp_unit,
	input	prf_code_t					i_dsp_src1_code,
	input	logic						i_dsp_src1_rdy,
	input	prf_code_t					i_dsp_src2_code,
	input	logic						i_dsp_src2_rdy,
	input	prf_code_t					i_dsp_dst_code,
	input	rob_id_t					i_dsp_rob_id,

	input	logic	[1:0]				i_wb_vld,
	input	prf_code_t					i_wb_code_0,
	input	prf_code_t					i_wb_code_1,

	input	logic						i_alu_grant,
	input	logic						i_mdu_grant,
	input	logic	[ENTRY_NUMS-1:0]	i_alu_sel,
	input	logic	[ENTRY_NUMS-1:0]	i_mdu_sel,

	output	logic						o_rsv_full,
	output	logic	[ENTRY_NUMS-1:0]	o_dsp_onehot_alu,
	output	logic	[ENTRY_NUMS-1:0]	o_dsp_onehot_mdu,
	output	logic	[ENTRY_NUMS-1:0]	o_alu_rdy_vec,
	output	logic	[ENTRY_NUMS-1:0]	o_mdu_rdy_vec,

	output	prf_code_t					o_alu_src1_code,
	output	prf_code_t					o_alu_src2_code,
	output	prf_code_t					o_alu_dst_code,
	output	rob_id_t					o_alu_rob_id,
	output	prf_code_t					o_mdu_src1_code,
	output	prf_code_t					o_mdu_src2_code,
	output	prf_code_t					o_mdu_dst_code,
	output	rob_id_t					o_mdu_rob_id
);

logic		[ENTRY_NUMS-1:0]	ent_vld;
exec_unit_e						ent_unit [ENTRY_NUMS];
prf_code_t						ent_src1_code [ENTRY_NUMS];
prf_code_t						ent_src2_code [ENTRY_NUMS];
logic		[ENTRY_NUMS-1:0]	ent_src1_rdy;
logic		[ENTRY_NUMS-1:0]	ent_src2_rdy;
prf_code_t						ent_dst_code [ENTRY_NUMS];
rob_id_t						ent_rob_id [ENTRY_NUMS];

logic		[ENTRY_NUMS-1:0]	free_vec;
logic		[ENTRY_NUMS-1:0]	dsp_onehot;
logic							dsp_take;
logic							dsp_src1_hit;
logic							dsp_src2_hit;
logic		[ENTRY_NUMS-1:0]	src1_wake;
logic		[ENTRY_NUMS-1:0]	src2_wake;
logic		[ENTRY_NUMS-1:0]	issue_clr;
logic		[ENTRY_NUMS-1:0]	ent_rdy;
logic		[ENTRY_NUMS-1:0]	ent_is_alu;

assign o_rsv_full = &ent_vld;
assign dsp_take   = i_dsp_vld & ~o_rsv_full;

// lowest free entry
assign free_vec   = ~ent_vld;
assign dsp_onehot = dsp_take ? (free_vec & (~free_vec + 1'b1)) : '0;

assign o_dsp_onehot_alu = (i_dsp_unit == UNIT_ALU)    ? dsp_onehot : '0;
assign o_dsp_onehot_mdu = (i_dsp_unit == UNIT_MULDIV) ? dsp_onehot : '0;

assign issue_clr = (i_alu_sel & {ENTRY_NUMS{i_alu_grant}})
				 | (i_mdu_sel & {ENTRY_NUMS{i_mdu_grant}});

// writeback code match, for stored and incoming sources
always_comb begin
	dsp_src1_hit = (i_wb_vld[0] && (i_dsp_src1_code == i_wb_code_0))
				|| (i_wb_vld[1] && (i_dsp_src1_code == i_wb_code_1));
	dsp_src2_hit = (i_wb_vld[0] && (i_dsp_src2_code == i_wb_code_0))
				|| (i_wb_vld[1] && (i_dsp_src2_code == i_wb_code_1));
	for (int i = 0; i < ENTRY_NUMS; i++) begin
		src1_wake[i] = (i_wb_vld[0] && (ent_src1_code[i] == i_wb_code_0))
					|| (i_wb_vld[1] && (ent_src1_code[i] == i_wb_code_1));
		src2_wake[i] = (i_wb_vld[0] && (ent_src2_code[i] == i_wb_code_0))
					|| (i_wb_vld[1] && (ent_src2_code[i] == i_wb_code_1));
	end
end

always_ff @(posedge clk) begin
	if (i_rst || i_flush) begin
		ent_vld <= '0;
	end else begin
		ent_vld <= (ent_vld & ~issue_clr) | dsp_onehot;
	end
end

always_ff @(posedge clk) begin
	for (int i = 0; i < ENTRY_NUMS; i++) begin
		if (dsp_onehot[i]) begin
			ent_unit[i]      <= i_dsp_unit;
			ent_src1_code[i] <= i_dsp_src1_code;
			ent_src2_code[i] <= i_dsp_src2_code;
			ent_src1_rdy[i]  <= i_dsp_src1_rdy | dsp_src1_hit;
			ent_src2_rdy[i]  <= i_dsp_src2_rdy | dsp_src2_hit;
			ent_dst_code[i]  <= i_dsp_dst_code;
			ent_rob_id[i]    <= i_dsp_rob_id;
		end else begin
			if (src1_wake[i])
				ent_src1_rdy[i] <= 1'b1;
			if (src2_wake[i])
				ent_src2_rdy[i] <= 1'b1;
		end
	end
end

always_comb begin
	for (int i = 0; i < ENTRY_NUMS; i++) begin
		ent_rdy[i]    = ent_vld[i] & ent_src1_rdy[i] & ent_src2_rdy[i];
		ent_is_alu[i] = (ent_unit[i] == UNIT_ALU);
	end
end

assign o_alu_rdy_vec = ent_rdy & ent_is_alu;
assign o_mdu_rdy_vec = ent_rdy & ~ent_is_alu;

// payload of the selected entry, sel is one-hot per class
always_comb begin
	o_alu_src1_code = '0;
	o_alu_src2_code = '0;
	o_alu_dst_code  = '0;
	o_alu_rob_id    = '0;
	o_mdu_src1_code = '0;
	o_mdu_src2_code = '0;
	o_mdu_dst_code  = '0;
	o_mdu_rob_id    = '0;
	for (int i = 0; i < ENTRY_NUMS; i++) begin
		if (i_alu_sel[i]) begin
			o_alu_src1_code = ent_src1_code[i];
			o_alu_src2_code = ent_src2_code[i];
			o_alu_dst_code  = ent_dst_code[i];
			o_alu_rob_id    = ent_rob_id[i];
		end
		if (i_mdu_sel[i]) begin
			o_mdu_src1_code = ent_src1_code[i];
			o_mdu_src2_code = ent_src2_code[i];
			o_mdu_dst_code  = ent_dst_code[i];
			o_mdu_rob_id    = ent_rob_id[i];
		end
	end
end

endmodule

// File: logic/rsv_age_mtrx.sv
`timescale 1ns/1ns

module rsv_age_mtrx #(
	parameter int ENTRY_NUMS = 8
) (
	input	logic						clk,
	input	logic						i_rst,
	input	logic						i_flush,

	input	logic	[ENTRY_NUMS-1:0]	i_dsp_onehot,
	input	logic	[ENTRY_NUMS-1:0]	i_rdy_vec,

	output	logic	[ENTRY_NUMS-1:0]	o_oldest_sel
);

// older[r][c] set means entry c was dispatched before entry r
logic	[ENTRY_NUMS-1:0]	older [ENTRY_NUMS];

always_ff @(posedge clk) begin
	if (i_rst || i_flush) begin
		for (int r = 0; r < ENTRY_NUMS; r++) begin
			older[r] <= '0;
		end
	end else begin
		for (int r = 0; r < ENTRY_NUMS; r++) begin
			for (int c = 0; c < ENTRY_NUMS; c++) begin
				// new entry is younger than all others
				if (i_dsp_onehot[r])
					older[r][c] <= (c != r);
				else if (i_dsp_onehot[c])
					older[r][c] <= 1'b0;
			end
		end
	end
end

// ready entry with no ready entry ahead of it
always_comb begin
	for (int r = 0; r < ENTRY_NUMS; r++) begin
		o_oldest_sel[r] = i_rdy_vec[r] & ~|(older[r] & i_rdy_vec);
	end
end

endmodule

// File: logic/rsv_issue_arb.sv
`timescale 1ns/1ns

module rsv_issue_arb
	import rsv_cfg_pkg::*;
	import rsv_unit_pkg::*;
(
	input	logic		clk,
	input	logic		i_rst,
	input	logic		i_flush,

	input	logic		i_alu_req,
	input	logic		i_mdu_req,
	input	prf_code_t	i_alu_src1_code,
	input	prf_code_t	i_alu_src2_code,
	input	prf_code_t	i_alu_dst_code,
	input	rob_id_t	i_alu_rob_id,
	input	prf_code_t	i_mdu_src1_code,
	input	prf_code_t	i_mdu_src2_code,
	input	prf_code_t	i_mdu_dst_code,
	input	rob_id_t	i_mdu_rob_id,

	input	prf_data_t	i_rd_dat_0,
	input	prf_data_t	i_rd_dat_1,
	output	prf_code_t	o_rd_code_0,
	output	prf_code_t	o_rd_code_1,

	output	logic		o_alu_grant,
	output	logic		o_mdu_grant,

	output	logic		o_alu_issue_vld,
	output	prf_data_t	o_alu_src1_dat,
	output	prf_data_t	o_alu_src2_dat,
	output	prf_code_t	o_alu_dst_code,
	output	rob_id_t	o_alu_rob_id,
	output	logic		o_mdu_issue_vld,
	output	prf_data_t	o_mdu_src1_dat,
	output	prf_data_t	o_mdu_src2_dat,
	output	prf_code_t	o_mdu_dst_code,
	output	rob_id_t	o_mdu_rob_id
);

arb_last_e	last_q;

// on a tie the class that lost last time goes first, the loser retries
assign o_alu_grant = i_alu_req & (~i_mdu_req | (last_q == LAST_MULDIV));
assign o_mdu_grant = i_mdu_req & (~i_alu_req | (last_q == LAST_ALU));

assign o_rd_code_0 = o_mdu_grant ? i_mdu_src1_code : i_alu_src1_code;
assign o_rd_code_1 = o_mdu_grant ? i_mdu_src2_code : i_alu_src2_code;

always_ff @(posedge clk) begin
	if (i_rst) begin
		last_q <= LAST_MULDIV;
	end else if (o_alu_grant) begin
		last_q <= LAST_ALU;
	end else if (o_mdu_grant) begin
		last_q <= LAST_MULDIV;
	end
end

always_ff @(posedge clk) begin
	if (i_rst || i_flush) begin
		o_alu_issue_vld <= 1'b0;
		o_mdu_issue_vld <= 1'b0;
	end else begin
		o_alu_issue_vld <= o_alu_grant;
		o_mdu_issue_vld <= o_mdu_grant;
	end
end

// issue payload, only meaningful with its vld
always_ff @(posedge clk) begin
	if (o_alu_grant) begin
		o_alu_src1_dat <= i_rd_dat_0;
		o_alu_src2_dat <= i_rd_dat_1;
		o_alu_dst_code <= i_alu_dst_code;
		o_alu_rob_id   <= i_alu_rob_id;
	end
	if (o_mdu_grant) begin
		o_mdu_src1_dat <= i_rd_dat_0;
		o_mdu_src2_dat <= i_rd_dat_1;
		o_mdu_dst_code <= i_mdu_dst_code;
		o_mdu_rob_id   <= i_mdu_rob_id;
	end
end

endmodule

// File: logic/rsv_prf.sv
`timescale 1ns/1ns

module rsv_prf
	import rsv_cfg_pkg::*;
#(
	parameter int PRF_NUMS = 32
) (
	input	logic			clk,
	input	logic			i_rst,

	input	logic	[1:0]	i_wr_en,
	input	prf_code_t		i_wr_code_0,
	input	prf_code_t		i_wr_code_1,
	input	prf_data_t		i_wr_dat_0,
	input	prf_data_t		i_wr_dat_1,

	input	prf_code_t		i_rd_code_0,
	input	prf_code_t		i_rd_code_1,
	output	prf_data_t		o_rd_dat_0,
	output	prf_data_t		o_rd_dat_1
);

prf_data_t	regs [PRF_NUMS];

always_ff @(posedge clk) begin
	if (i_rst) begin
		for (int i = 0; i < PRF_NUMS; i++) begin
			regs[i] <= '0;
		end
	end else begin
		if (i_wr_en[0])
			regs[i_wr_code_0] <= i_wr_dat_0;
		// port 1 last so it wins on the same code
		if (i_wr_en[1])
			regs[i_wr_code_1] <= i_wr_dat_1;
	end
end

// read is combinational, the arbiter registers it
assign o_rd_dat_0 = regs[i_rd_code_0];
assign o_rd_dat_1 = regs[i_rd_code_1];

endmodule

// File: logic/rsv_top.sv
`timescale 1ns/1ns

module rsv_top
	import rsv_cfg_pkg::*;
	import rsv_unit_pkg::*;
#(
	parameter int ENTRY_NUMS = 8,
	parameter int PRF_NUMS   = 32
) (
	input	logic			clk,
	input	logic			i_rst,
	input	logic			i_flush,

	input	logic			i_dsp_vld,
	input	exec_unit_e		i_dsp_unit,
	input	prf_code_t		i_dsp_src1_code,
	input	logic			i_dsp_src1_rdy,
	input	prf_code_t		i_dsp_src2_code,
	input	logic			i_dsp_src2_rdy,
	input	prf_code_t		i_dsp_dst_code,
	input	rob_id_t		i_dsp_rob_id,
	output	logic			o_rsv_full,

	input	logic	[1:0]	i_wb_vld,
	input	prf_code_t		i_wb_code_0,
	input	prf_code_t		i_wb_code_1,
	input	prf_data_t		i_wb_dat_0,
	input	prf_data_t		i_wb_dat_1,

	output	logic			o_alu_issue_vld,
	output	prf_data_t		o_alu_src1_dat,
	output	prf_data_t		o_alu_src2_dat,
	output	prf_code_t		o_alu_dst_code,
	output	rob_id_t		o_alu_rob_id,
	output	logic			o_mdu_issue_vld,
	output	prf_data_t		o_mdu_src1_dat,
	output	prf_data_t		o_mdu_src2_dat,
	output	prf_code_t		o_mdu_dst_code,
	output	rob_id_t		o_mdu_rob_id
);

logic	[ENTRY_NUMS-1:0]	dsp_onehot_alu;
logic	[ENTRY_NUMS-1:0]	dsp_onehot_mdu;
logic	[ENTRY_NUMS-1:0]	alu_rdy_vec;
logic	[ENTRY_NUMS-1:0]	mdu_rdy_vec;
logic	[ENTRY_NUMS-1:0]	alu_sel;
logic	[ENTRY_NUMS-1:0]	mdu_sel;
logic						alu_grant;
logic						mdu_grant;
prf_code_t					alu_src1_code;
prf_code_t					alu_src2_code;
prf_code_t					alu_dst_code;
rob_id_t					alu_rob_id;
prf_code_t					mdu_src1_code;
prf_code_t					mdu_src2_code;
prf_code_t					mdu_dst_code;
rob_id_t					mdu_rob_id;
prf_code_t					rd_code_0;
prf_code_t					rd_code_1;
prf_data_t					rd_dat_0;
prf_data_t					rd_dat_1;

rsv_entry_table #(
	.ENTRY_NUMS(ENTRY_NUMS)
) u_entry_table (
	.clk             (clk),
	.i_rst           (i_rst),
	.i_flush         (i_flush),
	.i_dsp_vld       (i_dsp_vld),
	.i_dsp_unit      (i_dsp_unit),
	.i_dsp_src1_code (i_dsp_src1_code),
	.i_dsp_src1_rdy  (i_dsp_src1_rdy),
	.i_dsp_src2_code (i_dsp_src2_code),
	.i_dsp_src2_rdy  (i_dsp_src2_rdy),
	.i_dsp_dst_code  (i_dsp_dst_code),
	.i_dsp_rob_id    (i_dsp_rob_id),
	.i_wb_vld        (i_wb_vld),
	.i_wb_code_0     (i_wb_code_0),
	.i_wb_code_1     (i_wb_code_1),
	.i_alu_grant     (alu_grant),
	.i_mdu_grant     (mdu_grant),
	.i_alu_sel       (alu_sel),
	.i_mdu_sel       (mdu_sel),
	.o_rsv_full      (o_rsv_full),
	.o_dsp_onehot_alu(dsp_onehot_alu),
	.o_dsp_onehot_mdu(dsp_onehot_mdu),
	.o_alu_rdy_vec   (alu_rdy_vec),
	.o_mdu_rdy_vec   (mdu_rdy_vec),
	.o_alu_src1_code (alu_src1_code),
	.o_alu_src2_code (alu_src2_code),
	.o_alu_dst_code  (alu_dst_code),
	.o_alu_rob_id    (alu_rob_id),
	.o_mdu_src1_code (mdu_src1_code),
	.o_mdu_src2_code (mdu_src2_code),
	.o_mdu_dst_code  (mdu_dst_code),
	.o_mdu_rob_id    (mdu_rob_id)
);

// one age matrix per class
rsv_age_mtrx #(
	.ENTRY_NUMS(ENTRY_NUMS)
) u_alu_age (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_flush     (i_flush),
	.i_dsp_onehot(dsp_onehot_alu),
	.i_rdy_vec   (alu_rdy_vec),
	.o_oldest_sel(alu_sel)
);

rsv_age_mtrx #(
	.ENTRY_NUMS(ENTRY_NUMS)
) u_mdu_age (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_flush     (i_flush),
	.i_dsp_onehot(dsp_onehot_mdu),
	.i_rdy_vec   (mdu_rdy_vec),
	.o_oldest_sel(mdu_sel)
);

rsv_issue_arb u_issue_arb (
	.clk            (clk),
	.i_rst          (i_rst),
	.i_flush        (i_flush),
	.i_alu_req      (|alu_sel),
	.i_mdu_req      (|mdu_sel),
	.i_alu_src1_code(alu_src1_code),
	.i_alu_src2_code(alu_src2_code),
	.i_alu_dst_code (alu_dst_code),
	.i_alu_rob_id   (alu_rob_id),
	.i_mdu_src1_code(mdu_src1_code),
	.i_mdu_src2_code(mdu_src2_code),
	.i_mdu_dst_code (mdu_dst_code),
	.i_mdu_rob_id   (mdu_rob_id),
	.i_rd_dat_0     (rd_dat_0),
	.i_rd_dat_1     (rd_dat_1),
	.o_rd_code_0    (rd_code_0),
	.o_rd_code_1    (rd_code_1),
	.o_alu_grant    (alu_grant),
	.o_mdu_grant    (mdu_grant),
	.o_alu_issue_vld(o_alu_issue_vld),
	.o_alu_src1_dat (o_alu_src1_dat),
	.o_alu_src2_dat (o_alu_src2_dat),
	.o_alu_dst_code (o_alu_dst_code),
	.o_alu_rob_id   (o_alu_rob_id),
	.o_mdu_issue_vld(o_mdu_issue_vld),
	.o_mdu_src1_dat (o_mdu_src1_dat),
	.o_mdu_src2_dat (o_mdu_src2_dat),
	.o_mdu_dst_code (o_mdu_dst_code),
	.o_mdu_rob_id   (o_mdu_rob_id)
);

rsv_prf #(
	.PRF_NUMS(PRF_NUMS)
) u_prf (
	.clk        (clk),
	.i_rst      (i_rst),
	.i_wr_en    (i_wb_vld),
	.i_wr_code_0(i_wb_code_0),
	.i_wr_code_1(i_wb_code_1),
	.i_wr_dat_0 (i_wb_dat_0),
	.i_wr_dat_1 (i_wb_dat_1),
	.i_rd_code_0(rd_code_0),
	.i_rd_code_1(rd_code_1),
	.o_rd_dat_0 (rd_dat_0),
	.o_rd_dat_1 (rd_dat_1)
);

endmodule

// File: sim/rsv_checker.sv
`timescale 1ns/1ns

module rsv_checker
	import rsv_cfg_pkg::*;
	import rsv_unit_pkg::*;
(
	input	logic		clk,
	input	logic		i_alu_issue_vld,
	input	prf_data_t	i_alu_src1_dat,
	input	prf_data_t	i_alu_src2_dat,
	input	prf_code_t	i_alu_dst_code,
	input	rob_id_t	i_alu_rob_id,
	input	logic		i_mdu_issue_vld,
	input	prf_data_t	i_mdu_src1_dat,
	input	prf_data_t	i_mdu_src2_dat,
	input	prf_code_t	i_mdu_dst_code,
	input	rob_id_t	i_mdu_rob_id,
	input	logic		i_rsv_full,
	input	logic		i_chk_full_en,
	input	logic		i_exp_full
);

int			err_cnt = 0;
string		cur_name = "reset";

// expected issue per rob id
logic		exp_known [64];
logic		exp_never [64];
exec_unit_e	exp_unit [64];
prf_data_t	exp_d1 [64];
prf_data_t	exp_d2 [64];
prf_code_t	exp_dst [64];
int			exp_seq [64];
string		exp_name [64];
int			issue_cnt [64];
int			last_seq [2];

initial begin
	for (int i = 0; i < 64; i++) begin
		exp_known[i] = 1'b0;
		issue_cnt[i] = 0;
	end
	last_seq[0] = 0;
	last_seq[1] = 0;
end

task automatic set_test_name(input string name);
	cur_name = name;
endtask

task automatic expect_issue(input string name, input rob_id_t rob, input exec_unit_e unit,
		input prf_data_t d1, input prf_data_t d2, input prf_code_t dst,
		input logic never, input int seq);
	exp_known[rob] = 1'b1;
	exp_never[rob] = never;
	exp_unit[rob]  = unit;
	exp_d1[rob]    = d1;
	exp_d2[rob]    = d2;
	exp_dst[rob]   = dst;
	exp_seq[rob]   = seq;
	exp_name[rob]  = name;
endtask

task automatic check_issue(input exec_unit_e unit, input rob_id_t rob, input prf_data_t d1,
		input prf_data_t d2, input prf_code_t dst);
	if (!exp_known[rob]) begin
		$display("ROB id %0d issued but was never dispatched", rob);
		err_cnt++;
		return;
	end
	issue_cnt[rob]++;
	if (exp_never[rob]) begin
		$display("%s: ROB id %0d issued although it was dropped", exp_name[rob], rob);
		err_cnt++;
	end else if (issue_cnt[rob] > 1) begin
		$display("%s: ROB id %0d issued more than once", exp_name[rob], rob);
		err_cnt++;
	end
	if (unit != exp_unit[rob]) begin
		$display("FAIL %s rob %0d class expected %0d actual %0d",
			exp_name[rob], rob, exp_unit[rob], unit);
		err_cnt++;
	end
	if (d1 !== exp_d1[rob]) begin
		$display("FAIL %s rob %0d src1 expected %h actual %h", exp_name[rob], rob, exp_d1[rob], d1);
		err_cnt++;
	end
	if (d2 !== exp_d2[rob]) begin
		$display("FAIL %s rob %0d src2 expected %h actual %h", exp_name[rob], rob, exp_d2[rob], d2);
		err_cnt++;
	end
	if (dst !== exp_dst[rob]) begin
		$display("FAIL %s rob %0d dst expected %0d actual %0d",
			exp_name[rob], rob, exp_dst[rob], dst);
		err_cnt++;
	end
	// dispatch order within one class
	if (exp_seq[rob] > 0) begin
		if (exp_seq[rob] <= last_seq[unit]) begin
			$display("FAIL %s rob %0d order expected after %0d actual %0d",
				exp_name[rob], rob, last_seq[unit], exp_seq[rob]);
			err_cnt++;
		end
		last_seq[unit] = exp_seq[rob];
	end
endtask

task automatic final_check();
	for (int i = 0; i < 64; i++) begin
		if (exp_known[i] && !exp_never[i] && issue_cnt[i] == 0) begin
			$display("%s: ROB id %0d never issued", exp_name[i], i);
			err_cnt++;
		end
	end
endtask

// outputs are registered, so the falling edge sees them settled
always @(negedge clk) begin
	if (i_alu_issue_vld && i_mdu_issue_vld) begin
		$display("%s: ALU and MULDIV issued in the same cycle", cur_name);
		err_cnt++;
	end
	if (i_alu_issue_vld === 1'b1)
		check_issue(UNIT_ALU, i_alu_rob_id, i_alu_src1_dat, i_alu_src2_dat, i_alu_dst_code);
	if (i_mdu_issue_vld === 1'b1)
		check_issue(UNIT_MULDIV, i_mdu_rob_id, i_mdu_src1_dat, i_mdu_src2_dat, i_mdu_dst_code);
	if (i_chk_full_en && (i_rsv_full !== i_exp_full)) begin
		$display("FAIL %s full expected %0d actual %0d", cur_name, i_exp_full, i_rsv_full);
		err_cnt++;
	end
end

endmodule

// File: sim/rsv_tb.sv
`timescale 1ns/1ns

module rsv_tb
	import rsv_cfg_pkg::*;
	import rsv_unit_pkg::*;
();

localparam int ENTRY_NUMS = 8;
localparam int PRF_NUMS   = 32;
localparam int MAX_ROWS   = 128;

localparam int K_IDLE  = 0;
localparam int K_DSP   = 1;
localparam int K_WB    = 2;
localparam int K_FLUSH = 3;
localparam int K_FULL  = 4;

logic		clk;
logic		i_rst;
logic		i_flush;
logic		i_dsp_vld;
exec_unit_e	i_dsp_unit;
prf_code_t	i_dsp_src1_code;
logic		i_dsp_src1_rdy;
prf_code_t	i_dsp_src2_code;
logic		i_dsp_src2_rdy;
prf_code_t	i_dsp_dst_code;
rob_id_t	i_dsp_rob_id;
logic		o_rsv_full;
logic [1:0]	i_wb_vld;
prf_code_t	i_wb_code_0;
prf_code_t	i_wb_code_1;
prf_data_t	i_wb_dat_0;
prf_data_t	i_wb_dat_1;
logic		o_alu_issue_vld;
prf_data_t	o_alu_src1_dat;
prf_data_t	o_alu_src2_dat;
prf_code_t	o_alu_dst_code;
rob_id_t	o_alu_rob_id;
logic		o_mdu_issue_vld;
prf_data_t	o_mdu_src1_dat;
prf_data_t	o_mdu_src2_dat;
prf_code_t	o_mdu_dst_code;
rob_id_t	o_mdu_rob_id;
logic		chk_full_en;
logic		exp_full;

// stimulus table
// wb rows carry port 0 in c1/r1/d1 and port 1 in c2/r2/d2
int			n_rows = 0;
int			row_kind [MAX_ROWS];
string		row_name [MAX_ROWS];
exec_unit_e	row_unit [MAX_ROWS];
prf_code_t	row_c1 [MAX_ROWS];
logic		row_r1 [MAX_ROWS];
prf_code_t	row_c2 [MAX_ROWS];
logic		row_r2 [MAX_ROWS];
prf_code_t	row_dst [MAX_ROWS];
rob_id_t	row_rob [MAX_ROWS];
prf_data_t	row_d1 [MAX_ROWS];
prf_data_t	row_d2 [MAX_ROWS];
logic		row_never [MAX_ROWS];
int			row_seq [MAX_ROWS];

int			cycles = 0;
int			cycle_limit = 0;

rsv_top #(
	.ENTRY_NUMS(ENTRY_NUMS),
	.PRF_NUMS  (PRF_NUMS)
) u_dut (
	.clk(clk), .i_rst(i_rst), .i_flush(i_flush),
	.i_dsp_vld(i_dsp_vld), .i_dsp_unit(i_dsp_unit),
	.i_dsp_src1_code(i_dsp_src1_code), .i_dsp_src1_rdy(i_dsp_src1_rdy),
	.i_dsp_src2_code(i_dsp_src2_code), .i_dsp_src2_rdy(i_dsp_src2_rdy),
	.i_dsp_dst_code(i_dsp_dst_code), .i_dsp_rob_id(i_dsp_rob_id),
	.o_rsv_full(o_rsv_full),
	.i_wb_vld(i_wb_vld), .i_wb_code_0(i_wb_code_0), .i_wb_code_1(i_wb_code_1),
	.i_wb_dat_0(i_wb_dat_0), .i_wb_dat_1(i_wb_dat_1),
	.o_alu_issue_vld(o_alu_issue_vld), .o_alu_src1_dat(o_alu_src1_dat),
	.o_alu_src2_dat(o_alu_src2_dat), .o_alu_dst_code(o_alu_dst_code),
	.o_alu_rob_id(o_alu_rob_id),
	.o_mdu_issue_vld(o_mdu_issue_vld), .o_mdu_src1_dat(o_mdu_src1_dat),
	.o_mdu_src2_dat(o_mdu_src2_dat), .o_mdu_dst_code(o_mdu_dst_code),
	.o_mdu_rob_id(o_mdu_rob_id)
);

rsv_checker u_chk (
	.clk(clk),
	.i_alu_issue_vld(o_alu_issue_vld), .i_alu_src1_dat(o_alu_src1_dat),
	.i_alu_src2_dat(o_alu_src2_dat), .i_alu_dst_code(o_alu_dst_code),
	.i_alu_rob_id(o_alu_rob_id),
	.i_mdu_issue_vld(o_mdu_issue_vld), .i_mdu_src1_dat(o_mdu_src1_dat),
	.i_mdu_src2_dat(o_mdu_src2_dat), .i_mdu_dst_code(o_mdu_dst_code),
	.i_mdu_rob_id(o_mdu_rob_id),
	.i_rsv_full(o_rsv_full), .i_chk_full_en(chk_full_en), .i_exp_full(exp_full)
);

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycle_limit > 0 && cycles >= cycle_limit) begin
		$display("run did not finish within %0d cycles", cycle_limit);
		$display("SIMULATION FAILED");
		$finish;
	end
end

task automatic add_row(input int kind, input string name, input exec_unit_e unit,
		input prf_code_t c1, input logic r1, input prf_code_t c2, input logic r2,
		input prf_code_t dst, input rob_id_t rob, input prf_data_t d1, input prf_data_t d2,
		input logic never, input int seq);
	row_kind[n_rows]  = kind;
	row_name[n_rows]  = name;
	row_unit[n_rows]  = unit;
	row_c1[n_rows]    = c1;
	row_r1[n_rows]    = r1;
	row_c2[n_rows]    = c2;
	row_r2[n_rows]    = r2;
	row_dst[n_rows]   = dst;
	row_rob[n_rows]   = rob;
	row_d1[n_rows]    = d1;
	row_d2[n_rows]    = d2;
	row_never[n_rows] = never;
	row_seq[n_rows]   = seq;
	n_rows++;
endtask

task automatic add_idle(input string name, input int n);
	for (int i = 0; i < n; i++)
		add_row(K_IDLE, name, UNIT_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
endtask

task automatic add_full_chk(input string name, input logic full);
	add_row(K_FULL, name, UNIT_ALU, 0, full, 0, 0, 0, 0, 0, 0, 0, 0);
endtask

task automatic clear_inputs();
	i_flush     = 1'b0;
	i_dsp_vld   = 1'b0;
	i_wb_vld    = 2'b00;
	chk_full_en = 1'b0;
endtask

task automatic build_table();
	add_full_chk("reset", 1'b0);
	// ready dispatch
	add_row(K_WB, "ready", UNIT_ALU, 1, 1, 2, 1, 0, 0, 32'h11111111, 32'h22222222, 0, 0);
	add_row(K_DSP, "ready", UNIT_ALU, 1, 1, 2, 1, 10, 1, 32'h11111111, 32'h22222222, 0, 0);
	add_idle("ready", 3);
	// wakeup on writeback
	add_row(K_DSP, "wakeup", UNIT_ALU, 3, 0, 1, 1, 11, 2, 32'h33333333, 32'h11111111, 0, 0);
	add_idle("wakeup", 3);
	add_row(K_WB, "wakeup", UNIT_ALU, 3, 1, 0, 0, 0, 0, 32'h33333333, 0, 0, 0);
	add_idle("wakeup", 3);
	// three MULDIV ops on one code
	for (int i = 0; i < 3; i++)
		add_row(K_DSP, "age", UNIT_MULDIV, 4, 0, 2, 1, prf_code_t'(12 + i), rob_id_t'(3 + i),
			32'h44444444, 32'h22222222, 0, i + 1);
	add_idle("age", 1);
	add_row(K_WB, "age", UNIT_ALU, 4, 1, 0, 0, 0, 0, 32'h44444444, 0, 0, 0);
	add_idle("age", 5);
	// both classes wake on code 7 and contend for the read ports
	add_row(K_DSP, "shared", UNIT_ALU, 1, 1, 7, 0, 15, 6, 32'h11111111, 32'h77777777, 0, 0);
	add_row(K_DSP, "shared", UNIT_MULDIV, 2, 1, 7, 0, 16, 7, 32'h22222222, 32'h77777777, 0, 0);
	add_row(K_DSP, "shared", UNIT_ALU, 3, 1, 7, 0, 17, 8, 32'h33333333, 32'h77777777, 0, 0);
	add_row(K_DSP, "shared", UNIT_MULDIV, 4, 1, 7, 0, 18, 9, 32'h44444444, 32'h77777777, 0, 0);
	add_row(K_WB, "shared", UNIT_ALU, 7, 1, 0, 0, 0, 0, 32'h77777777, 0, 0, 0);
	add_idle("shared", 8);
	// fill all entries waiting on code 5
	for (int i = 0; i < ENTRY_NUMS; i++)
		add_row(K_DSP, "full", (i < 4) ? UNIT_ALU : UNIT_MULDIV, 5, 0, 1, 1,
			prf_code_t'(20 + i), rob_id_t'(10 + i), 32'h55555555, 32'h11111111, 0, 0);
	add_full_chk("full", 1'b1);
	add_row(K_DSP, "full", UNIT_ALU, 1, 1, 2, 1, 28, 18, 0, 0, 1, 0);
	add_row(K_WB, "full", UNIT_ALU, 5, 1, 0, 0, 0, 0, 32'h55555555, 0, 0, 0);
	add_idle("full", 10);
	add_full_chk("full", 1'b0);
	// flush drops a full station of waiting entries
	for (int i = 0; i < ENTRY_NUMS; i++)
		add_row(K_DSP, "flush", (i < 4) ? UNIT_ALU : UNIT_MULDIV, 6, 0, 1, 1,
			prf_code_t'(20 + i), rob_id_t'(20 + i), 0, 0, 1, 0);
	add_full_chk("flush", 1'b1);
	add_row(K_FLUSH, "flush", UNIT_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	add_full_chk("flush", 1'b0);
	add_row(K_WB, "flush", UNIT_ALU, 6, 1, 0, 0, 0, 0, 32'h66666666, 0, 0, 0);
	add_idle("flush", 5);
	add_row(K_DSP, "flush", UNIT_ALU, 6, 1, 1, 1, 31, 28, 32'h66666666, 32'h11111111, 0, 0);
	add_idle("flush", 3);
endtask

initial begin
	i_rst = 1'b1;
	i_dsp_unit = UNIT_ALU;
	i_dsp_src1_code = '0;
	i_dsp_src1_rdy = 1'b0;
	i_dsp_src2_code = '0;
	i_dsp_src2_rdy = 1'b0;
	i_dsp_dst_code = '0;
	i_dsp_rob_id = '0;
	i_wb_code_0 = '0;
	i_wb_code_1 = '0;
	i_wb_dat_0 = '0;
	i_wb_dat_1 = '0;
	exp_full = 1'b0;
	clear_inputs();
	build_table();
	cycle_limit = n_rows * 4 + 50;
	repeat (8) @(posedge clk);
	#2 i_rst = 1'b0;
	for (int i = 0; i < n_rows; i++) begin
		@(posedge clk);
		#2;
		clear_inputs();
		u_chk.set_test_name(row_name[i]);
		case (row_kind[i])
			K_DSP: begin
				i_dsp_vld       = 1'b1;
				i_dsp_unit      = row_unit[i];
				i_dsp_src1_code = row_c1[i];
				i_dsp_src1_rdy  = row_r1[i];
				i_dsp_src2_code = row_c2[i];
				i_dsp_src2_rdy  = row_r2[i];
				i_dsp_dst_code  = row_dst[i];
				i_dsp_rob_id    = row_rob[i];
				u_chk.expect_issue(row_name[i], row_rob[i], row_unit[i], row_d1[i], row_d2[i],
					row_dst[i], row_never[i], row_seq[i]);
			end
			K_WB: begin
				i_wb_vld    = {row_r2[i], row_r1[i]};
				i_wb_code_0 = row_c1[i];
				i_wb_dat_0  = row_d1[i];
				i_wb_code_1 = row_c2[i];
				i_wb_dat_1  = row_d2[i];
			end
			K_FLUSH: i_flush = 1'b1;
			K_FULL: begin
				chk_full_en = 1'b1;
				exp_full    = row_r1[i];
			end
			default: ;
		endcase
	end
	@(posedge clk);
	#2;
	clear_inputs();
	repeat (10) @(posedge clk);
	u_chk.final_check();
	$display("errors: %0d", u_chk.err_cnt);
	if (u_chk.err_cnt == 0) begin
		$display("SIMULATION PASSED");
	end else begin
		$display("SIMULATION FAILED");
	end
	$finish;
end

endmodule

// File: filelist.f
logic/rsv_cfg_pkg.sv
logic/rsv_unit_pkg.sv
logic/rsv_entry_table.sv
logic/rsv_age_mtrx.sv
logic/rsv_issue_arb.sv
logic/rsv_prf.sv
logic/rsv_top.sv
sim/rsv_checker.sv
sim/rsv_tb.sv

// File: run.sh
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rsv_tb -f filelist.f -o rsv_sim \
	> build.log 2>&1 \
	&& ./obj_dir/rsv_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
